/* Bender.yml */
package:
  name: nes_core_glue

sources:
  - verilog/nes_glue_pkg.sv
  - verilog/bridge_settings_decode.sv
  - verilog/pad_map.sv
  - verilog/video_out_shaper.sv
  - verilog/nes_core_glue.sv
  - target: test
    files:
      - test/nes_core_checker.sv
      - test/tb_nes_core_glue.sv

/* nes_core_glue.f */
verilog/nes_glue_pkg.sv
verilog/bridge_settings_decode.sv
verilog/pad_map.sv
verilog/video_out_shaper.sv
verilog/nes_core_glue.sv
test/nes_core_checker.sv
test/tb_nes_core_glue.sv

/* test/nes_core_checker.sv */
//////////////////////////////////////////////////
// reference model of the glue outputs, one edge late
// expected settings come from the stimulus table
// compares on the falling edge, outputs are stable
//////////////////////////////////////////////////

`timescale 1ns/1ps

module nes_core_checker
  import nes_glue_pkg::*;
#(
  parameter int hs_delay = def_hs_delay
) (
  input  logic                    clk_74a,
  input  logic                    pll_core_locked,
  input  logic [key_w-1:0]        cont1_key,
  input  logic [key_w-1:0]        cont2_key,
  input  logic [key_w-1:0]        cont3_key,
  input  logic [key_w-1:0]        cont4_key,
  input  logic                    h_blank,
  input  logic                    v_blank,
  input  logic                    hsync_in,
  input  logic                    vsync_in,
  input  logic [rgb_w-1:0]        rgb_in,
  // {hide, mask[1:0], extra, palette[2:0], multitap, yb}
  input  logic [8:0]              exp_settings,
  input  logic                    hide_overscan,
  input  logic [mask_edges_w-1:0] mask_vid_edges,
  input  logic                    allow_extra_sprites,
  input  logic [palette_w-1:0]    selected_palette,
  input  logic                    multitap_enabled,
  input  logic                    yb_map_enable,
  input  logic [nes_pad_w-1:0]    p1_pad,
  input  logic [nes_pad_w-1:0]    p2_pad,
  input  logic [nes_pad_w-1:0]    p3_pad,
  input  logic [nes_pad_w-1:0]    p4_pad,
  input  logic [rgb_w-1:0]        video_rgb,
  input  logic                    video_de,
  input  logic                    video_hs,
  input  logic                    video_vs,
  output int                      set_errors,
  output int                      pad_errors,
  output int                      vid_errors
);

  int                   n_set = 0;
  int                   n_pad = 0;
  int                   n_vid = 0;
  int                   cyc;
  int                   last_rise;
  logic                 rise_seen;
  logic [8:0]           exp_set_q;
  logic [8:0]           settings_now;
  logic [nes_pad_w-1:0] exp_p1;
  logic [nes_pad_w-1:0] exp_p2;
  logic [nes_pad_w-1:0] exp_p3;
  logic [nes_pad_w-1:0] exp_p4;
  logic                 de_now;
  logic                 de_prev_m;
  logic                 hs_prev_m;
  logic                 vs_prev_m;
  logic                 exp_de;
  logic                 exp_hs;
  logic                 exp_vs;
  logic [rgb_w-1:0]     exp_rgb;
  logic [rgb_w-1:0]     slot_word;

  assign set_errors = n_set;
  assign pad_errors = n_pad;
  assign vid_errors = n_vid;

  assign settings_now = {hide_overscan, mask_vid_edges, allow_extra_sprites,
                         selected_palette, multitap_enabled, yb_map_enable};
  assign de_now = !h_blank && !v_blank;

  always_comb begin
    slot_word                    = '0;
    slot_word[slot_overscan_bit] = exp_set_q[8];
  end

  // NES order from bit 7 down: right left down up start select b a
  function automatic logic [nes_pad_w-1:0] expect_pad(input logic [key_w-1:0] k,
                                                      input logic             yb);
    logic btn_a;
    logic btn_b;
    btn_a = yb ? k[key_face_b] : k[key_face_a];
    btn_b = yb ? k[key_face_y] : k[key_face_b];
    return {k[key_right], k[key_left], k[key_down], k[key_up],
            k[key_start], k[key_select], btn_b, btn_a};
  endfunction

  //////////////////////////////////////////////////
  // model, sampled on the same edge as the DUT

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      exp_set_q <= '0;
      exp_p1    <= '0;
      exp_p2    <= '0;
      exp_p3    <= '0;
      exp_p4    <= '0;
      exp_de    <= 1'b0;
      exp_rgb   <= '0;
      exp_hs    <= 1'b0;
      exp_vs    <= 1'b0;
      de_prev_m <= 1'b0;
      hs_prev_m <= 1'b0;
      vs_prev_m <= 1'b0;
      cyc       <= 0;
      last_rise <= 0;
      rise_seen <= 1'b0;
    end else begin
      exp_set_q <= exp_settings;
      // remap uses the yb setting held at this edge
      exp_p1    <= expect_pad(cont1_key, exp_set_q[0]);
      exp_p2    <= expect_pad(cont2_key, 1'b0);
      exp_p3    <= expect_pad(cont3_key, 1'b0);
      exp_p4    <= expect_pad(cont4_key, 1'b0);
      exp_de    <= de_now;
      de_prev_m <= de_now;
      exp_rgb   <= de_now ? rgb_in : (de_prev_m ? slot_word : '0);
      cyc       <= cyc + 1;
      hs_prev_m <= hsync_in;
      vs_prev_m <= vsync_in;
      if (hsync_in && !hs_prev_m) begin
        last_rise <= cyc;
        rise_seen <= 1'b1;
      end
      // pulse lands hs_delay edges after the latest rise
      exp_hs <= rise_seen && (cyc == last_rise + hs_delay);
      exp_vs <= vsync_in && !vs_prev_m;
    end
  end

  //////////////////////////////////////////////////
  // compare

  always @(negedge clk_74a) begin
    if (settings_now !== exp_set_q) begin
      n_set++;
      $display("ERROR %0t: settings %b expected %b", $time, settings_now, exp_set_q);
    end
    if ({p1_pad, p2_pad, p3_pad, p4_pad} !== {exp_p1, exp_p2, exp_p3, exp_p4}) begin
      n_pad++;
      $display("ERROR %0t: pads %h %h %h %h expected %h %h %h %h", $time,
               p1_pad, p2_pad, p3_pad, p4_pad, exp_p1, exp_p2, exp_p3, exp_p4);
    end
    if (video_de !== exp_de || video_rgb !== exp_rgb) begin
      n_vid++;
      $display("ERROR %0t: de %b rgb %h expected de %b rgb %h", $time,
               video_de, video_rgb, exp_de, exp_rgb);
    end
    if (video_hs !== exp_hs || video_vs !== exp_vs) begin
      n_vid++;
      $display("ERROR %0t: hs %b vs %b expected hs %b vs %b", $time,
               video_hs, video_vs, exp_hs, exp_vs);
    end
  end

endmodule

/* test/tb_nes_core_glue.sv */
//////////////////////////////////////////////////
// drives the glue top from a row table, one row
// per clock, keys from an LFSR when a row asks
// the checker module does all the comparing
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_nes_core_glue
  import nes_glue_pkg::*;
();

  localparam int pulse_timeout = 20;

  // settings field order {hide, mask[1:0], extra, palette[2:0], multitap, yb}
  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic        rnd;
    logic [15:0] key;
    logic [3:0]  vid;
    logic [23:0] rgb;
    logic [8:0]  exp_set;
  } row_t;

  logic                     clk_74a;
  logic                     pll_core_locked;
  logic [bridge_addr_w-1:0] bridge_addr;
  logic                     bridge_wr;
  logic [bridge_addr_w-1:0] bridge_wr_data;
  logic [key_w-1:0]         cont1_key;
  logic [key_w-1:0]         cont2_key;
  logic [key_w-1:0]         cont3_key;
  logic [key_w-1:0]         cont4_key;
  logic                     h_blank;
  logic                     v_blank;
  logic                     hsync_in;
  logic                     vsync_in;
  logic [rgb_w-1:0]         rgb_in;
  logic                     hide_overscan;
  logic [mask_edges_w-1:0]  mask_vid_edges;
  logic                     allow_extra_sprites;
  logic [palette_w-1:0]     selected_palette;
  logic                     multitap_enabled;
  logic                     yb_map_enable;
  logic [nes_pad_w-1:0]     p1_pad;
  logic [nes_pad_w-1:0]     p2_pad;
  logic [nes_pad_w-1:0]     p3_pad;
  logic [nes_pad_w-1:0]     p4_pad;
  logic [rgb_w-1:0]         video_rgb;
  logic                     video_de;
  logic                     video_hs;
  logic                     video_vs;
  logic [8:0]               exp_settings;
  int                       set_errors;
  int                       pad_errors;
  int                       vid_errors;
  logic [31:0]              lfsr_state;
  bit                       timed_out;
  row_t                     rows [$];

  nes_core_glue #(
    .num_players(4),
    .hs_delay   (7)
  ) i_nes_core_glue (.*);

  nes_core_checker #(
    .hs_delay(7)
  ) i_checker (.*);

  initial begin
    clk_74a = 1'b0;
    forever #10 clk_74a = ~clk_74a;
  end

  //////////////////////////////////////////////////
  // stimulus helpers

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic rand_key(output logic [key_w-1:0] key);
    for (int i = 0; i < key_w; i++) begin
      key[i]     = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // vid is {h_blank, v_blank, hsync_in, vsync_in}
  task automatic add_row(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                         input logic rnd, input logic [15:0] key, input logic [3:0] vid,
                         input logic [23:0] rgb, input logic [8:0] exp_set);
    row_t r;
    r.wr      = wr;
    r.addr    = addr;
    r.data    = data;
    r.rnd     = rnd;
    r.key     = key;
    r.vid     = vid;
    r.rgb     = rgb;
    r.exp_set = exp_set;
    rows.push_back(r);
  endtask

  // raise one sync and wait for its output pulse
  task automatic drive_sync_and_wait(input bit vertical, inout bit timeout_seen);
    int n;
    if (!timeout_seen) begin
      @(posedge clk_74a);
      if (vertical) begin
        vsync_in <= 1'b1;
      end else begin
        hsync_in <= 1'b1;
      end
      n = 0;
      @(negedge clk_74a);
      while (((vertical ? video_vs : video_hs) !== 1'b1) && (n < pulse_timeout)) begin
        @(negedge clk_74a);
        n++;
      end
      if (n >= pulse_timeout) begin
        $display("timeout: no %s pulse within %0d cycles", vertical ? "video_vs" : "video_hs",
                 pulse_timeout);
        timeout_seen = 1'b1;
      end
      @(posedge clk_74a);
      hsync_in <= 1'b0;
      vsync_in <= 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    logic [key_w-1:0] k1;
    logic [key_w-1:0] k2;
    logic [key_w-1:0] k3;
    logic [key_w-1:0] k4;
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    cont1_key       = '0;
    cont2_key       = '0;
    cont3_key       = '0;
    cont4_key       = '0;
    h_blank         = 1'b1;
    v_blank         = 1'b1;
    hsync_in        = 1'b0;
    vsync_in        = 1'b0;
    rgb_in          = '0;
    exp_settings    = '0;
    lfsr_state      = 32'h44fb;
    timed_out       = 1'b0;

    // settings, wide data and stray addresses
    add_row(1, 32'h200, 32'hFFFF_FFFF, 0, 16'h0, 4'b1100, 24'h0, 9'b1_00_0_000_0_0);
    add_row(1, 32'h204, 32'hFFFF_FFFE, 0, 16'h0, 4'b1100, 24'h0, 9'b1_10_0_000_0_0);
    add_row(1, 32'h208, 32'h0000_0003, 0, 16'h0, 4'b1100, 24'h0, 9'b1_10_1_000_0_0);
    add_row(1, 32'h20C, 32'hFFFF_FFFD, 0, 16'h0, 4'b1100, 24'h0, 9'b1_10_1_101_0_0);
    add_row(1, 32'h300, 32'h0000_0001, 0, 16'h0, 4'b1100, 24'h0, 9'b1_10_1_101_1_0);
    add_row(1, 32'h206, 32'hFFFF_FFFF, 0, 16'h0, 4'b1100, 24'h0, 9'b1_10_1_101_1_0);
    add_row(1, 32'h1200, 32'hFFFF_FFFF, 0, 16'h0, 4'b1100, 24'h0, 9'b1_10_1_101_1_0);
    add_row(0, 32'h310, 32'h0000_0001, 0, 16'hc0b5, 4'b1100, 24'h0, 9'b1_10_1_101_1_0);
    // pads without and with the remap
    for (int i = 0; i < 4; i++) begin
      add_row(0, 32'h0, 32'h0, 1, 16'h0, 4'b1100, 24'h0, 9'b1_10_1_101_1_0);
    end
    add_row(1, 32'h310, 32'h0000_0001, 1, 16'h0, 4'b1100, 24'h0, 9'b1_10_1_101_1_1);
    for (int i = 0; i < 4; i++) begin
      add_row(0, 32'h0, 32'h0, 1, 16'h0, 4'b1100, 24'h0, 9'b1_10_1_101_1_1);
    end
    add_row(0, 32'h0, 32'h0, 0, 16'hffff, 4'b1100, 24'h0, 9'b1_10_1_101_1_1);
    // active video and slot word, overscan on
    add_row(0, 32'h0, 32'h0, 1, 16'h0, 4'b0000, 24'h123456, 9'b1_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 1, 16'h0, 4'b0000, 24'habcdef, 9'b1_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 1, 16'h0, 4'b1000, 24'h777777, 9'b1_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 1, 16'h0, 4'b1000, 24'h777777, 9'b1_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b0100, 24'h555555, 9'b1_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b0000, 24'h00ff00, 9'b1_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b0100, 24'h111111, 9'b1_10_1_101_1_1);
    // overscan off, slot word goes to zero
    add_row(1, 32'h200, 32'h0000_0000, 0, 16'h0, 4'b1100, 24'h0, 9'b0_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b0000, 24'hc0ffee, 9'b0_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b1100, 24'hffffff, 9'b0_10_1_101_1_1);
    // hsync rise, restart, then a vsync rise
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b1110, 24'h0, 9'b0_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b1100, 24'h0, 9'b0_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b1110, 24'h0, 9'b0_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b1110, 24'h0, 9'b0_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b1101, 24'h0, 9'b0_10_1_101_1_1);
    add_row(0, 32'h0, 32'h0, 0, 16'h0, 4'b1101, 24'h0, 9'b0_10_1_101_1_1);
    for (int i = 0; i < 10; i++) begin
      add_row(0, 32'h0, 32'h0, 1, 16'h0, 4'b1100, 24'h0, 9'b0_10_1_101_1_1);
    end

    repeat (4) @(posedge clk_74a);
    pll_core_locked <= 1'b1;

    foreach (rows[i]) begin
      @(posedge clk_74a);
      if (rows[i].rnd) begin
        rand_key(k1);
        rand_key(k2);
        rand_key(k3);
        rand_key(k4);
      end else begin
        k1 = rows[i].key;
        k2 = rows[i].key;
        k3 = rows[i].key;
        k4 = rows[i].key;
      end
      bridge_wr      <= rows[i].wr;
      bridge_addr    <= rows[i].addr;
      bridge_wr_data <= rows[i].data;
      cont1_key      <= k1;
      cont2_key      <= k2;
      cont3_key      <= k3;
      cont4_key      <= k4;
      {h_blank, v_blank, hsync_in, vsync_in} <= rows[i].vid;
      rgb_in         <= rows[i].rgb;
      exp_settings   <= rows[i].exp_set;
    end

    drive_sync_and_wait(1'b0, timed_out);
    drive_sync_and_wait(1'b1, timed_out);
    repeat (3) @(posedge clk_74a);
    @(negedge clk_74a);

    $display("errors: settings %0d, pads %0d, video %0d, timeouts %0d",
             set_errors, pad_errors, vid_errors, timed_out);
    if (timed_out || (set_errors + pad_errors + vid_errors) != 0) begin
      $display("Test FAILED");
    end else begin
      $display("Test OK");
    end
    $finish;
  end

endmodule

/* verilog/bridge_settings_decode.sv */
//////////////////////////////////////////////////
// option registers written over the bridge bus
// writes take effect on the strobe edge, no readback
// unknown addresses are ignored
//////////////////////////////////////////////////

`timescale 1ns/1ps

module bridge_settings_decode
  import nes_glue_pkg::*;
(
  input  logic                     clk_74a,
  input  logic                     pll_core_locked,
  input  logic                     bridge_wr,
  input  logic [bridge_addr_w-1:0] bridge_addr,
  input  logic [bridge_addr_w-1:0] bridge_wr_data,
  output logic                     hide_overscan,
  output logic [mask_edges_w-1:0]  mask_vid_edges,
  output logic                     allow_extra_sprites,
  output logic [palette_w-1:0]     selected_palette,
  output logic                     multitap_enabled,
  output logic                     yb_map_enable
);

  //////////////////////////////////////////////////
  // write decode

  // full address match, only the low data bits land in a field
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hide_overscan       <= 1'b0;
      mask_vid_edges      <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      multitap_enabled    <= 1'b0;
      yb_map_enable       <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        addr_hide_overscan: begin
          hide_overscan <= bridge_wr_data[0];
        end
        addr_mask_edges: begin
          mask_vid_edges <= bridge_wr_data[mask_edges_w-1:0];
        end
        addr_extra_sprites: begin
          allow_extra_sprites <= bridge_wr_data[0];
        end
        addr_palette: begin
          selected_palette <= bridge_wr_data[palette_w-1:0];
        end
        addr_multitap: begin
          multitap_enabled <= bridge_wr_data[0];
        end
        addr_yb_map: begin
          yb_map_enable <= bridge_wr_data[0];
        end
        default: begin
          // other bridge traffic belongs to other devices
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // checks

  // settings only move on a write strobe
  a_settings_hold : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !bridge_wr |=> $stable({hide_overscan, mask_vid_edges, allow_extra_sprites,
                            selected_palette, multitap_enabled, yb_map_enable})
  ) else $error("settings changed without a bridge write");

endmodule

/* verilog/nes_core_glue.sv */
//////////////////////////////////////////////////
// glue logic top level around the NES core
// one clock, clk_74a, reset from pll lock
//////////////////////////////////////////////////

`timescale 1ns/1ps

module nes_core_glue
  import nes_glue_pkg::*;
#(
  parameter int num_players = def_num_players,
  parameter int hs_delay    = def_hs_delay
) (
  input  logic                     clk_74a,
  input  logic                     pll_core_locked,

  // bridge bus
  input  logic [bridge_addr_w-1:0] bridge_addr,
  input  logic                     bridge_wr,
  input  logic [bridge_addr_w-1:0] bridge_wr_data,

  // controllers
  input  logic [key_w-1:0]         cont1_key,
  input  logic [key_w-1:0]         cont2_key,
  input  logic [key_w-1:0]         cont3_key,
  input  logic [key_w-1:0]         cont4_key,

  // video from the core
  input  logic                     h_blank,
  input  logic                     v_blank,
  input  logic                     hsync_in,
  input  logic                     vsync_in,
  input  logic [rgb_w-1:0]         rgb_in,

  // settings
  output logic                     hide_overscan,
  output logic [mask_edges_w-1:0]  mask_vid_edges,
  output logic                     allow_extra_sprites,
  output logic [palette_w-1:0]     selected_palette,
  output logic                     multitap_enabled,
  output logic                     yb_map_enable,

  // NES pads
  output logic [nes_pad_w-1:0]     p1_pad,
  output logic [nes_pad_w-1:0]     p2_pad,
  output logic [nes_pad_w-1:0]     p3_pad,
  output logic [nes_pad_w-1:0]     p4_pad,

  // video to the scaler
  output logic [rgb_w-1:0]         video_rgb,
  output logic                     video_de,
  output logic                     video_hs,
  output logic                     video_vs
);

  bridge_settings_decode i_decode (
    .clk_74a            (clk_74a),
    .pll_core_locked    (pll_core_locked),
    .bridge_wr          (bridge_wr),
    .bridge_addr        (bridge_addr),
    .bridge_wr_data     (bridge_wr_data),
    .hide_overscan      (hide_overscan),
    .mask_vid_edges     (mask_vid_edges),
    .allow_extra_sprites(allow_extra_sprites),
    .selected_palette   (selected_palette),
    .multitap_enabled   (multitap_enabled),
    .yb_map_enable      (yb_map_enable)
  );

  pad_map #(
    .num_players(num_players)
  ) i_pad_map (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .yb_map_enable  (yb_map_enable),
    .cont1_key      (cont1_key),
    .cont2_key      (cont2_key),
    .cont3_key      (cont3_key),
    .cont4_key      (cont4_key),
    .p1_pad         (p1_pad),
    .p2_pad         (p2_pad),
    .p3_pad         (p3_pad),
    .p4_pad         (p4_pad)
  );

  video_out_shaper #(
    .hs_delay(hs_delay)
  ) i_video (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .hide_overscan  (hide_overscan),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .hsync_in       (hsync_in),
    .vsync_in       (vsync_in),
    .rgb_in         (rgb_in),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

endmodule

/* verilog/nes_glue_pkg.sv */
//////////////////////////////////////////////////
// shared constants for the NES core glue logic
// bridge addresses are compared over all 32 bits
// key positions follow the handheld key bitmap
//////////////////////////////////////////////////

package nes_glue_pkg;

  //////////////////////////////////////////////////
  // bridge bus and settings

  localparam int bridge_addr_w = 32;

  localparam logic [bridge_addr_w-1:0] addr_hide_overscan = 32'h0000_0200;
  localparam logic [bridge_addr_w-1:0] addr_mask_edges    = 32'h0000_0204;
  localparam logic [bridge_addr_w-1:0] addr_extra_sprites = 32'h0000_0208;
  localparam logic [bridge_addr_w-1:0] addr_palette       = 32'h0000_020C;
  localparam logic [bridge_addr_w-1:0] addr_multitap      = 32'h0000_0300;
  localparam logic [bridge_addr_w-1:0] addr_yb_map        = 32'h0000_0310;

  localparam int mask_edges_w = 2;
  localparam int palette_w    = 3;

  //////////////////////////////////////////////////
  // controllers and NES pads

  localparam int key_w       = 16;
  localparam int nes_pad_w   = 8;
  localparam int max_players = 4;

  // NES button order inside a pad vector
  localparam int nes_btn_a      = 0;
  localparam int nes_btn_b      = 1;
  localparam int nes_btn_select = 2;
  localparam int nes_btn_start  = 3;
  localparam int nes_btn_up     = 4;
  localparam int nes_btn_down   = 5;
  localparam int nes_btn_left   = 6;
  localparam int nes_btn_right  = 7;

  // bits of the controller key word
  localparam int key_up     = 0;
  localparam int key_down   = 1;
  localparam int key_left   = 2;
  localparam int key_right  = 3;
  localparam int key_face_a = 4;
  localparam int key_face_b = 5;
  localparam int key_face_y = 7;
  localparam int key_select = 14;
  localparam int key_start  = 15;

  //////////////////////////////////////////////////
  // video

  localparam int rgb_w             = 24;
  localparam int slot_overscan_bit = 13;

  // defaults for the top level
  localparam int def_num_players = 4;
  localparam int def_hs_delay    = 7;

endpackage

/* verilog/pad_map.sv */
//////////////////////////////////////////////////
// key words to NES pads, one cycle of latency
// players above num_players read as all zeros
// only player 1 has the Y/B remap
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_map
  import nes_glue_pkg::*;
#(
  parameter int num_players = 4
) (
  input  logic                 clk_74a,
  input  logic                 pll_core_locked,
  input  logic                 yb_map_enable,
  input  logic [key_w-1:0]     cont1_key,
  input  logic [key_w-1:0]     cont2_key,
  input  logic [key_w-1:0]     cont3_key,
  input  logic [key_w-1:0]     cont4_key,
  output logic [nes_pad_w-1:0] p1_pad,
  output logic [nes_pad_w-1:0] p2_pad,
  output logic [nes_pad_w-1:0] p3_pad,
  output logic [nes_pad_w-1:0] p4_pad
);

  // remap moves A to face B and B to face Y
  function automatic logic [nes_pad_w-1:0] map_keys(input logic [key_w-1:0] key,
                                                    input logic             remap);
    logic [nes_pad_w-1:0] pad;
    pad                 = '0;
    pad[nes_btn_a]      = remap ? key[key_face_b] : key[key_face_a];
    pad[nes_btn_b]      = remap ? key[key_face_y] : key[key_face_b];
    pad[nes_btn_select] = key[key_select];
    pad[nes_btn_start]  = key[key_start];
    pad[nes_btn_up]     = key[key_up];
    pad[nes_btn_down]   = key[key_down];
    pad[nes_btn_left]   = key[key_left];
    pad[nes_btn_right]  = key[key_right];
    return pad;
  endfunction

  logic [key_w-1:0]     keys [max_players];
  logic [nes_pad_w-1:0] pads [max_players];

  assign keys[0] = cont1_key;
  assign keys[1] = cont2_key;
  assign keys[2] = cont3_key;
  assign keys[3] = cont4_key;

  //////////////////////////////////////////////////
  // per player registers

  for (genvar p = 0; p < max_players; p++) begin : g_player
    if (p < num_players) begin : g_on
      logic [nes_pad_w-1:0] pad_q;

      always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
          pad_q <= '0;
        end else begin
          pad_q <= map_keys(keys[p], (p == 0) ? yb_map_enable : 1'b0);
        end
      end

      assign pads[p] = pad_q;
    end else begin : g_off
      assign pads[p] = '0;
    end
  end

  assign p1_pad = pads[0];
  assign p2_pad = pads[1];
  assign p3_pad = pads[2];
  assign p4_pad = pads[3];

  // pads must be clean once out of reset
  a_pads_known : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !$isunknown({p1_pad, p2_pad, p3_pad, p4_pad})
  ) else $error("pad output unknown after reset");

endmodule

/* verilog/video_out_shaper.sv */
//////////////////////////////////////////////////
// registers video towards the scaler
// first blanked cycle after active video carries
// the slot word, hsync delayed by hs_delay cycles,
// vsync cut down to a one cycle pulse
//////////////////////////////////////////////////

`timescale 1ns/1ps

module video_out_shaper
  import nes_glue_pkg::*;
#(
  parameter int hs_delay = 7
) (
  input  logic             clk_74a,
  input  logic             pll_core_locked,
  input  logic             hide_overscan,
  input  logic             h_blank,
  input  logic             v_blank,
  input  logic             hsync_in,
  input  logic             vsync_in,
  input  logic [rgb_w-1:0] rgb_in,
  output logic [rgb_w-1:0] video_rgb,
  output logic             video_de,
  output logic             video_hs,
  output logic             video_vs
);

  localparam int cnt_w = $clog2(hs_delay + 1);

  logic             de;
  logic             de_prev;
  logic             hs_prev;
  logic             vs_prev;
  logic [cnt_w-1:0] hs_cnt;
  logic [rgb_w-1:0] slot_rgb;

  // active video when neither blank is set
  assign de = ~(h_blank | v_blank);

  // slot word, everything zero except the overscan flag
  assign slot_rgb = rgb_w'(hide_overscan) << slot_overscan_bit;

  //////////////////////////////////////////////////
  // data enable and colour

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      de_prev   <= 1'b0;
    end else begin
      video_de <= de;
      de_prev  <= de;
      if (de) begin
        video_rgb <= rgb_in;
      end else if (de_prev) begin
        // falling edge of enable
        video_rgb <= slot_rgb;
      end else begin
        video_rgb <= '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // horizontal sync

  // a rising edge loads the counter, pulse when it passes 1
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev  <= 1'b0;
      hs_cnt   <= '0;
      video_hs <= 1'b0;
    end else begin
      hs_prev  <= hsync_in;
      video_hs <= (hs_cnt == cnt_w'(1));
      if (hsync_in && !hs_prev) begin
        hs_cnt <= cnt_w'(hs_delay);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - cnt_w'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // vertical sync

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      vs_prev  <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      vs_prev  <= vsync_in;
      video_vs <= vsync_in & ~vs_prev;
    end
  end

  // syncs to the scaler are single cycle pulses
  a_hs_pulse : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs
  ) else $error("video_hs high for more than one cycle");

  a_vs_pulse : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs
  ) else $error("video_vs high for more than one cycle");

endmodule
